/* design/kotku_pkg.sv */
`default_nettype none

package kotku_pkg;

  typedef logic [15:0] bus_data_t;
  typedef logic [1:0]  bus_sel_t;
  typedef logic [19:0] bus_addr_t;   // {io tag, word address 19..1}
  typedef logic [19:0] pc_t;
  typedef logic [6:0]  seg7_t;       // Active low, bit 0 is segment a
  typedef logic [9:0]  sw_t;
  typedef logic [13:0] led_t;

  localparam int unsigned NUM_EXT_SLAVES = 10;

  typedef logic [NUM_EXT_SLAVES-1:0] ext_sel_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t dat;
    bus_sel_t  sel;
    logic      we;
    logic      cyc;
    logic      stb;
  } cpu_req_t;

  typedef struct packed {
    bus_data_t dat;
    logic      ack;
  } cpu_rsp_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t dat;
    bus_sel_t  sel;
    logic      we;
    logic      stb;
  } slave_req_t;

  typedef struct packed {
    bus_data_t dat;
    logic      ack;
  } slave_rsp_t;

  typedef slave_rsp_t [NUM_EXT_SLAVES-1:0] slave_rsp_vec_t;

  // External slave ports
  localparam int unsigned SLV_ROM   = 0;
  localparam int unsigned SLV_VGA   = 1;
  localparam int unsigned SLV_UART  = 2;
  localparam int unsigned SLV_KEYB  = 3;
  localparam int unsigned SLV_AUDIO = 4;
  localparam int unsigned SLV_SD    = 5;
  localparam int unsigned SLV_CSR   = 6;
  localparam int unsigned SLV_TIMER = 7;
  localparam int unsigned SLV_FLASH = 8;
  localparam int unsigned SLV_SDRAM = 9;

  // Address regions, tag bit first
  localparam bus_addr_t ROM_BASE      = 20'b0_1111_1111_1111_0000_000; // mem fff00
  localparam bus_addr_t ROM_MASK      = 20'b1_1111_1111_1111_0000_000;
  localparam bus_addr_t VGA_MEM_BASE  = 20'b0_1011_1000_0000_0000_000; // mem b8000
  localparam bus_addr_t VGA_MEM_MASK  = 20'b1_1111_1000_0000_0000_000;
  localparam bus_addr_t VGA_IO_BASE   = 20'b1_0000_0000_0011_1100_000; // io 3c0-3df
  localparam bus_addr_t VGA_IO_MASK   = 20'b1_0000_1111_1111_1110_000;
  localparam bus_addr_t UART_BASE     = 20'b1_0000_0000_0011_1111_100; // io 3f8-3ff
  localparam bus_addr_t UART_MASK     = 20'b1_0000_1111_1111_1111_100;
  localparam bus_addr_t KEYB_BASE     = 20'b1_0000_0000_0000_0110_000; // io 60, 64
  localparam bus_addr_t KEYB_MASK     = 20'b1_0000_1111_1111_1111_101;
  localparam bus_addr_t SD_BASE       = 20'b1_0000_0000_0001_0000_000; // io 100-101
  localparam bus_addr_t SD_MASK       = 20'b1_0000_1111_1111_1111_111;
  localparam bus_addr_t GPIO_BASE     = 20'b1_0000_1111_0001_0000_000; // io f100-f103
  localparam bus_addr_t GPIO_MASK     = 20'b1_0000_1111_1111_1111_110;
  localparam bus_addr_t CSR_BASE      = 20'b1_0000_1111_0010_0000_000; // io f200-f20f
  localparam bus_addr_t CSR_MASK      = 20'b1_0000_1111_1111_1111_000;
  localparam bus_addr_t TIMER_BASE    = 20'b1_0000_0000_0000_0100_000; // io 40-43
  localparam bus_addr_t TIMER_MASK    = 20'b1_0000_1111_1111_1111_110;
  localparam bus_addr_t FLASH_BASE    = 20'b1_0000_0000_0010_0011_100; // io 238-23b
  localparam bus_addr_t FLASH_MASK    = 20'b1_0000_1111_1111_1111_110;
  localparam bus_addr_t SDRAM_IO_BASE = 20'b1_0000_1111_0011_0000_000; // io f300-f3ff
  localparam bus_addr_t SDRAM_IO_MASK = 20'b1_0000_1111_1111_0000_000;
  localparam bus_addr_t SDRAM_MEM_BASE = 20'b0_0000_0000_0000_0000_000; // all memory
  localparam bus_addr_t SDRAM_MEM_MASK = 20'b1_0000_0000_0000_0000_000;

  localparam bus_data_t IRQ_VECTOR_BASE   = 16'h0008;
  localparam bus_data_t DEFAULT_READ_DATA = 16'hFFFF;
  localparam int unsigned RST_HOLD_CYCLES = 16;

endpackage

`default_nettype wire

/* design/soc_reset_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_reset_gen (
  input  logic clk,
  input  logic rst_lck,
  input  logic pll_lock_i,
  input  logic sw0_i,
  output logic sys_rst_o
);
  import kotku_pkg::*;

  localparam int unsigned CNT_W = $clog2(RST_HOLD_CYCLES + 1);

  logic             rst_src;
  logic [CNT_W-1:0] hold_cnt;

  // Lock input, PLL lock and the push switch all force reset
  assign rst_src = !rst_lck || !pll_lock_i || sw0_i;

  always_ff @(posedge clk) begin
    if (rst_src) begin
      hold_cnt <= CNT_W'(RST_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
    sys_rst_o <= rst_src || (hold_cnt != '0);  // Stays up until count drains
  end

endmodule

`default_nettype wire

/* design/bus_address_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_address_decoder (
  input  kotku_pkg::cpu_req_t   m_req_i,
  output kotku_pkg::slave_req_t s_req_o,
  output kotku_pkg::ext_sel_t   s_cyc_o,
  output logic                  gpio_cyc_o,
  output logic                  dflt_cyc_o,
  output kotku_pkg::ext_sel_t   sel_ext_o
);
  import kotku_pkg::*;

  // External slaves, then GPIO, then the default slave on top
  logic [NUM_EXT_SLAVES+1:0] sel_onehot;
  logic                      aud_cond;
  bus_addr_t                 addr;

  function automatic logic region_hit(bus_addr_t a, bus_addr_t base, bus_addr_t mask);
    return ((a ^ base) & mask) == '0;
  endfunction

  assign addr = m_req_i.addr;

  // High byte of port 61h belongs to the speaker
  assign aud_cond = (addr[1:0] == 2'b00) && m_req_i.sel[1];

  always_comb begin
    sel_onehot = '0;
    if (region_hit(addr, ROM_BASE, ROM_MASK)) begin
      sel_onehot[SLV_ROM] = 1'b1;
    end else if (region_hit(addr, VGA_MEM_BASE, VGA_MEM_MASK) ||
                 region_hit(addr, VGA_IO_BASE, VGA_IO_MASK)) begin
      sel_onehot[SLV_VGA] = 1'b1;
    end else if (region_hit(addr, UART_BASE, UART_MASK)) begin
      sel_onehot[SLV_UART] = 1'b1;
    end else if (region_hit(addr, KEYB_BASE, KEYB_MASK)) begin
      if (aud_cond) sel_onehot[SLV_AUDIO] = 1'b1;
      else          sel_onehot[SLV_KEYB]  = 1'b1;
    end else if (region_hit(addr, SD_BASE, SD_MASK)) begin
      sel_onehot[SLV_SD] = 1'b1;
    end else if (region_hit(addr, GPIO_BASE, GPIO_MASK)) begin
      sel_onehot[NUM_EXT_SLAVES] = 1'b1;      // Internal GPIO block
    end else if (region_hit(addr, CSR_BASE, CSR_MASK)) begin
      sel_onehot[SLV_CSR] = 1'b1;
    end else if (region_hit(addr, TIMER_BASE, TIMER_MASK)) begin
      sel_onehot[SLV_TIMER] = 1'b1;
    end else if (region_hit(addr, FLASH_BASE, FLASH_MASK)) begin
      sel_onehot[SLV_FLASH] = 1'b1;
    end else if (region_hit(addr, SDRAM_IO_BASE, SDRAM_IO_MASK) ||
                 region_hit(addr, SDRAM_MEM_BASE, SDRAM_MEM_MASK)) begin
      sel_onehot[SLV_SDRAM] = 1'b1;
    end else begin
      sel_onehot[NUM_EXT_SLAVES+1] = 1'b1;    // Nobody claimed it
    end
  end

  assign sel_ext_o  = sel_onehot[NUM_EXT_SLAVES-1:0];
  assign s_cyc_o    = sel_ext_o & {NUM_EXT_SLAVES{m_req_i.cyc}};
  assign gpio_cyc_o = sel_onehot[NUM_EXT_SLAVES] & m_req_i.cyc;
  assign dflt_cyc_o = sel_onehot[NUM_EXT_SLAVES+1] & m_req_i.cyc;

  // Same request fields go to every slave
  assign s_req_o.addr = m_req_i.addr;
  assign s_req_o.dat  = m_req_i.dat;
  assign s_req_o.sel  = m_req_i.sel;
  assign s_req_o.we   = m_req_i.we;
  assign s_req_o.stb  = m_req_i.stb;

endmodule

`default_nettype wire

/* design/bus_response_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_response_mux (
  input  kotku_pkg::ext_sel_t       sel_ext_i,
  input  logic                      gpio_cyc_i,
  input  logic                      dflt_cyc_i,
  input  logic                      stb_i,
  input  kotku_pkg::slave_rsp_vec_t s_rsp_i,
  input  kotku_pkg::slave_rsp_t     gpio_rsp_i,
  input  logic                      inta_i,
  input  logic [2:0]                iid_i,
  output kotku_pkg::cpu_rsp_t       m_rsp_o
);
  import kotku_pkg::*;

  bus_data_t bus_dat;
  logic      bus_ack;
  bus_data_t irq_vector;

  always_comb begin
    bus_dat = '0;
    bus_ack = 1'b0;
    for (int k = 0; k < NUM_EXT_SLAVES; k++) begin
      if (sel_ext_i[k]) begin
        bus_dat |= s_rsp_i[k].dat;
        bus_ack |= s_rsp_i[k].ack;
      end
    end

    // Speaker is byte wide and answers on the high lane
    if (sel_ext_i[SLV_AUDIO]) begin
      bus_dat = {s_rsp_i[SLV_AUDIO].dat[7:0], 8'h00};
    end

    if (gpio_cyc_i) begin
      bus_dat = gpio_rsp_i.dat;
      bus_ack = gpio_rsp_i.ack;
    end

    if (dflt_cyc_i) begin
      bus_dat = DEFAULT_READ_DATA;
      bus_ack = stb_i;            // Zero wait state
    end
  end

  assign irq_vector = IRQ_VECTOR_BASE + {13'b0, iid_i};

  assign m_rsp_o.dat = inta_i ? irq_vector : bus_dat;
  assign m_rsp_o.ack = bus_ack;

endmodule

`default_nettype wire

/* design/gpio_sw_leds.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_sw_leds (
  input  logic                  clk,
  input  logic                  sys_rst_i,
  input  logic                  cyc_i,
  input  kotku_pkg::slave_req_t req_i,
  input  kotku_pkg::sw_t        sw_i,
  output kotku_pkg::slave_rsp_t rsp_o,
  output kotku_pkg::led_t       leds_o
);
  import kotku_pkg::*;

  logic      access;
  bus_data_t rd_dat;

  // New access only while no ack is out, so the ack is one cycle wide
  assign access = cyc_i && req_i.stb && !rsp_o.ack;

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      rsp_o.ack <= 1'b0;
      leds_o    <= '0;
    end else begin
      rsp_o.ack <= access;
      if (access && req_i.we && req_i.addr[0]) begin
        if (req_i.sel[0]) leds_o[7:0]  <= req_i.dat[7:0];
        if (req_i.sel[1]) leds_o[13:8] <= req_i.dat[13:8];
      end
    end
  end

  assign rd_dat = req_i.addr[0] ? bus_data_t'(leds_o) : bus_data_t'(sw_i);

  always_ff @(posedge clk) begin
    if (access) rsp_o.dat <= rd_dat;  // Lines up with the ack
  end

endmodule

`default_nettype wire

/* design/pc_hex_display.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_hex_display (
  input  kotku_pkg::pc_t   pc_i,
  output kotku_pkg::seg7_t hex0_o,
  output kotku_pkg::seg7_t hex1_o,
  output kotku_pkg::seg7_t hex2_o,
  output kotku_pkg::seg7_t hex3_o,
  output logic [3:0]       ledg_lo_o
);
  import kotku_pkg::*;

  // Segments gfedcba, a lit segment is 0
  function automatic seg7_t hex_to_seg(logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  assign hex0_o = hex_to_seg(pc_i[7:4]);
  assign hex1_o = hex_to_seg(pc_i[11:8]);
  assign hex2_o = hex_to_seg(pc_i[15:12]);
  assign hex3_o = hex_to_seg(pc_i[19:16]);

  assign ledg_lo_o = pc_i[3:0];  // Lowest nibble shown on LEDs

endmodule

`default_nettype wire

/* design/kotku_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module kotku_bus (
  input  logic                      clk,
  input  logic                      rst_lck,
  input  logic                      pll_lock_i,
  input  kotku_pkg::sw_t            sw_i,
  input  kotku_pkg::cpu_req_t       m_req_i,
  output kotku_pkg::cpu_rsp_t       m_rsp_o,
  input  logic                      inta_i,
  input  logic [2:0]                iid_i,
  input  kotku_pkg::pc_t            pc_i,
  output logic                      sys_rst_o,
  output kotku_pkg::slave_req_t     s_req_o,
  output kotku_pkg::ext_sel_t       s_cyc_o,
  input  kotku_pkg::slave_rsp_vec_t s_rsp_i,
  output kotku_pkg::seg7_t          hex0_o,
  output kotku_pkg::seg7_t          hex1_o,
  output kotku_pkg::seg7_t          hex2_o,
  output kotku_pkg::seg7_t          hex3_o,
  output logic [9:0]                ledr_o,
  output logic [7:0]                ledg_o
);
  import kotku_pkg::*;

  logic       gpio_cyc;
  logic       dflt_cyc;
  ext_sel_t   sel_ext;
  slave_rsp_t gpio_rsp;
  led_t       leds;

  soc_reset_gen soc_reset_gen_i (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .pll_lock_i (pll_lock_i),
    .sw0_i      (sw_i[0]),
    .sys_rst_o  (sys_rst_o)
  );

  bus_address_decoder bus_address_decoder_i (
    .m_req_i    (m_req_i),
    .s_req_o    (s_req_o),
    .s_cyc_o    (s_cyc_o),
    .gpio_cyc_o (gpio_cyc),
    .dflt_cyc_o (dflt_cyc),
    .sel_ext_o  (sel_ext)
  );

  bus_response_mux bus_response_mux_i (
    .sel_ext_i  (sel_ext),
    .gpio_cyc_i (gpio_cyc),
    .dflt_cyc_i (dflt_cyc),
    .stb_i      (m_req_i.stb),
    .s_rsp_i    (s_rsp_i),
    .gpio_rsp_i (gpio_rsp),
    .inta_i     (inta_i),
    .iid_i      (iid_i),
    .m_rsp_o    (m_rsp_o)
  );

  gpio_sw_leds gpio_sw_leds_i (
    .clk       (clk),
    .sys_rst_i (sys_rst_o),
    .cyc_i     (gpio_cyc),
    .req_i     (s_req_o),
    .sw_i      (sw_i),
    .rsp_o     (gpio_rsp),
    .leds_o    (leds)
  );

  pc_hex_display pc_hex_display_i (
    .pc_i      (pc_i),
    .hex0_o    (hex0_o),
    .hex1_o    (hex1_o),
    .hex2_o    (hex2_o),
    .hex3_o    (hex3_o),
    .ledg_lo_o (ledg_o[3:0])
  );

  // Red LEDs take the upper bits, green the rest
  assign ledr_o      = leds[13:4];
  assign ledg_o[7:4] = leds[3:0];

endmodule

`default_nettype wire

/* verification/kotku_bus_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module kotku_bus_assertions (
  input logic                clk,
  input logic                rst_lck,
  input logic                sys_rst_o,
  input kotku_pkg::cpu_req_t m_req_i,
  input kotku_pkg::cpu_rsp_t m_rsp_o,
  input kotku_pkg::ext_sel_t s_cyc_o
);

  int unsigned fail_cnt = 0;

  cyc_onehot: assert property (@(posedge clk) $onehot0(s_cyc_o))
    else begin
      fail_cnt++;
      $error("More than one slave cycle line set");
    end

  // Every ack belongs to an open master cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (sys_rst_o)
                                 m_rsp_o.ack |-> m_req_i.cyc)
    else begin
      fail_cnt++;
      $error("Ack seen without a master cycle");
    end

  lock_reset: assert property (@(posedge clk) !rst_lck |=> sys_rst_o)
    else begin
      fail_cnt++;
      $error("System reset missing after lock input went low");
    end

endmodule

bind kotku_bus kotku_bus_assertions kotku_bus_assertions_i (
  .clk       (clk),
  .rst_lck   (rst_lck),
  .sys_rst_o (sys_rst_o),
  .m_req_i   (m_req_i),
  .m_rsp_o   (m_rsp_o),
  .s_cyc_o   (s_cyc_o)
);

`default_nettype wire

/* verification/kotku_bus_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module kotku_bus_tb;
  import kotku_pkg::*;

  localparam time         DRV_DLY   = 1ns;
  localparam int unsigned NUM_TESTS = 6;

  logic           clk = 1'b0;
  logic           rst_lck;
  logic           pll_lock;
  sw_t            sw;
  cpu_req_t       m_req;
  cpu_rsp_t       m_rsp;
  logic           inta;
  logic [2:0]     iid;
  pc_t            pc;
  logic           sys_rst;
  slave_req_t     s_req;
  ext_sel_t       s_cyc;
  slave_rsp_vec_t s_rsp;
  seg7_t          hex [4];
  logic [9:0]     ledr;
  logic [7:0]     ledg;

  integer         seed;
  integer         rnd;
  logic [1:0]     slv_wait;   // Wait states left for the current slave access
  logic           slv_busy;
  bus_data_t      rdat;
  ext_sel_t       cyc_seen;
  slave_req_t     req_seen;
  int unsigned    lat;

  // Segments gfedcba lit when low
  seg7_t seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                            7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  always #4ns clk = ~clk;

  kotku_bus kotku_bus_i (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .pll_lock_i (pll_lock),
    .sw_i       (sw),
    .m_req_i    (m_req),
    .m_rsp_o    (m_rsp),
    .inta_i     (inta),
    .iid_i      (iid),
    .pc_i       (pc),
    .sys_rst_o  (sys_rst),
    .s_req_o    (s_req),
    .s_cyc_o    (s_cyc),
    .s_rsp_i    (s_rsp),
    .hex0_o     (hex[0]),
    .hex1_o     (hex[1]),
    .hex2_o     (hex[2]),
    .hex3_o     (hex[3]),
    .ledr_o     (ledr),
    .ledg_o     (ledg)
  );

  function automatic bus_addr_t io_addr(input logic [19:0] byte_addr);
    return {1'b1, byte_addr[19:1]};
  endfunction

  function automatic bus_addr_t mem_addr(input logic [19:0] byte_addr);
    return {1'b0, byte_addr[19:1]};
  endfunction

  function automatic bus_data_t slave_tag(input int unsigned k);
    return 16'hA000 + 16'(k);
  endfunction

  // External slaves answer with tagged data after random wait states
  always_comb begin
    for (int k = 0; k < NUM_EXT_SLAVES; k++) begin
      s_rsp[k].dat = slave_tag(k);
      s_rsp[k].ack = s_cyc[k] && s_req.stb && (slv_wait == 2'd0);
    end
  end

  always @(posedge clk) begin
    slv_busy = (s_cyc != '0) && s_req.stb;
    #DRV_DLY;
    if (slv_busy) begin
      if (slv_wait == 2'd0) begin
        rnd = $random(seed);   // Ack went out so pick the next delay
        slv_wait = rnd[1:0];
      end else begin
        slv_wait = slv_wait - 2'd1;
      end
    end
  end

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("Finished with errors");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // One strobe/ack cycle held until ack is seen
  task automatic bus_access(input bus_addr_t addr, input logic we, input bus_sel_t sel,
                            input bus_data_t wdat, output bus_data_t dat_o,
                            output ext_sel_t cyc_o, output slave_req_t req_o,
                            output int unsigned lat_o);
    @(posedge clk);
    #DRV_DLY;
    m_req = {addr, wdat, sel, we, 1'b1, 1'b1};
    lat_o = 0;
    @(negedge clk);
    cyc_o = s_cyc;
    req_o = s_req;
    while (!m_rsp.ack) begin
      lat_o++;
      @(negedge clk);
    end
    dat_o = m_rsp.dat;
    @(posedge clk);
    #DRV_DLY;
    m_req.cyc = 1'b0;
    m_req.stb = 1'b0;
    @(negedge clk);
    check("s_cyc_o while idle", s_cyc, 0);
  endtask

  // Caller has just released the last reset source
  task automatic release_timing();
    for (int n = 1; n <= RST_HOLD_CYCLES + 2; n++) begin
      @(negedge clk);
      check("sys_rst_o", sys_rst, n <= RST_HOLD_CYCLES + 1);
    end
  endtask

  task automatic reset_sequence();
    repeat (2) @(posedge clk);
    #DRV_DLY;
    rst_lck = 1'b1;
    release_timing();
    @(posedge clk);
    #DRV_DLY;
    sw[0] = 1'b1;
    @(negedge clk);
    check("sys_rst_o before switch reset", sys_rst, 0);
    @(negedge clk);
    check("sys_rst_o on switch reset", sys_rst, 1);
    @(posedge clk);
    #DRV_DLY;
    sw[0] = 1'b0;
    release_timing();
    @(posedge clk);
    #DRV_DLY;
    pll_lock = 1'b0;
    @(negedge clk);
    @(negedge clk);
    check("sys_rst_o on lost PLL lock", sys_rst, 1);
    @(posedge clk);
    #DRV_DLY;
    pll_lock = 1'b1;
    release_timing();
  endtask

  task automatic region_decode();
    bus_addr_t   addrs [11];
    int unsigned idx [11];
    bus_data_t   wdat;
    ext_sel_t    exp_sel;
    logic        we;
    addrs = '{mem_addr(20'hFFF00), mem_addr(20'hB8000), io_addr(20'h3C0), io_addr(20'h3F8),
              io_addr(20'h64), io_addr(20'h100), io_addr(20'hF200), io_addr(20'h40),
              io_addr(20'h238), io_addr(20'hF300), mem_addr(20'h12340)};
    idx = '{SLV_ROM, SLV_VGA, SLV_VGA, SLV_UART, SLV_KEYB, SLV_SD, SLV_CSR, SLV_TIMER,
            SLV_FLASH, SLV_SDRAM, SLV_SDRAM};
    for (int i = 0; i < 11; i++) begin
      wdat = 16'hC0DE ^ 16'(i);
      we = (i % 2) == 1;
      exp_sel = '0;
      exp_sel[idx[i]] = 1'b1;
      bus_access(addrs[i], we, 2'b11, wdat, rdat, cyc_seen, req_seen, lat);
      check("s_cyc_o", cyc_seen, exp_sel);
      check("s_req_o", req_seen, {addrs[i], wdat, 2'b11, we, 1'b1});
      check("m_rsp_o.dat", rdat, slave_tag(idx[i]));
    end
  endtask

  task automatic keyboard_speaker_split();
    bus_access(io_addr(20'h60), 1'b0, 2'b10, 16'h0, rdat, cyc_seen, req_seen, lat);
    check("s_cyc_o for port 61", cyc_seen, 1 << SLV_AUDIO);
    check("speaker read data", rdat, (slave_tag(SLV_AUDIO) & 16'h00FF) << 8);
    bus_access(io_addr(20'h60), 1'b0, 2'b01, 16'h0, rdat, cyc_seen, req_seen, lat);
    check("s_cyc_o for port 60", cyc_seen, 1 << SLV_KEYB);
    check("keyboard read data", rdat, slave_tag(SLV_KEYB));
    bus_access(io_addr(20'h64), 1'b1, 2'b11, 16'h00AE, rdat, cyc_seen, req_seen, lat);
    check("s_cyc_o for port 64", cyc_seen, 1 << SLV_KEYB);
  endtask

  task automatic default_slave_read();
    bus_access(io_addr(20'h300), 1'b0, 2'b11, 16'h0, rdat, cyc_seen, req_seen, lat);
    check("s_cyc_o for unmapped port", cyc_seen, 0);
    check("default read data", rdat, 16'hFFFF);
    check("default ack latency", lat, 0);
  endtask

  task automatic gpio_registers();
    bus_sel_t  sels [3];
    bus_data_t dats [3];
    led_t      led_exp;
    sels = '{2'b11, 2'b01, 2'b10};
    dats = '{16'h1234, 16'hFFCD, 16'hAB00};
    led_exp = '0;
    @(posedge clk);
    #DRV_DLY;
    sw = 10'h2A6;   // Bit 0 is the reset switch and stays low
    bus_access(io_addr(20'hF100), 1'b0, 2'b11, 16'h0, rdat, cyc_seen, req_seen, lat);
    check("switch read data", rdat, {6'b0, 10'h2A6});
    check("GPIO ack latency", lat, 1);
    check("s_cyc_o for GPIO", cyc_seen, 0);
    check("ledr_o after reset", ledr, 0);
    check("ledg_o[7:4] after reset", ledg[7:4], 0);
    for (int i = 0; i < 3; i++) begin
      bus_access(io_addr(20'hF102), 1'b1, sels[i], dats[i], rdat, cyc_seen, req_seen, lat);
      if (sels[i][0]) led_exp[7:0] = dats[i][7:0];
      if (sels[i][1]) led_exp[13:8] = dats[i][13:8];
      bus_access(io_addr(20'hF102), 1'b0, 2'b11, 16'h0, rdat, cyc_seen, req_seen, lat);
      check("LED read data", rdat, {2'b00, led_exp});
      check("ledr_o", ledr, led_exp[13:4]);
      check("ledg_o[7:4]", ledg[7:4], led_exp[3:0]);
    end
  endtask

  task automatic irq_vector_and_display();
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #DRV_DLY;
      inta = 1'b1;
      iid = 3'(i);
      bus_access(io_addr(20'h300), 1'b0, 2'b11, 16'h0, rdat, cyc_seen, req_seen, lat);
      check("interrupt vector", rdat, 16'h0008 + 16'(i));
    end
    @(posedge clk);
    #DRV_DLY;
    inta = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #DRV_DLY;
      rnd = $random(seed);
      pc = rnd[19:0];
      @(negedge clk);
      check("hex0_o", hex[0], seg_table[pc[7:4]]);
      check("hex1_o", hex[1], seg_table[pc[11:8]]);
      check("hex2_o", hex[2], seg_table[pc[15:12]]);
      check("hex3_o", hex[3], seg_table[pc[19:16]]);
      check("ledg_o[3:0]", ledg[3:0], pc[3:0]);
    end
  endtask

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $fatal(1, "Timeout");
  end

  initial begin
    seed = 81;
    rst_lck = 1'b0;
    pll_lock = 1'b1;
    sw = '0;
    m_req = '0;
    inta = 1'b0;
    iid = '0;
    pc = '0;
    rnd = $random(seed);
    slv_wait = rnd[1:0];
    reset_sequence();
    region_decode();
    keyboard_speaker_split();
    default_slave_read();
    gpio_registers();
    irq_vector_and_display();
    if (kotku_bus_i.kotku_bus_assertions_i.fail_cnt != 0) begin
      $display("Bound assertions failed during the run");
      $display("Finished with errors");
      $fatal(1, "Assertion failures");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* kotku_bus.f */
design/kotku_pkg.sv
design/soc_reset_gen.sv
design/bus_address_decoder.sv
design/bus_response_mux.sv
design/gpio_sw_leds.sv
design/pc_hex_display.sv
design/kotku_bus.sv
verification/kotku_bus_assertions.sv
verification/kotku_bus_tb.sv

/* Makefile */
TOP := kotku_bus_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f kotku_bus.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
